/* Makefile */
VERILATOR := verilator
TOP       := tb_stream_ram_writer
FILELIST  := list.f
FLAGS     := --binary --timing --assert -Wno-fatal
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* burst_writer.sv */
`timescale 1ns/10ps

module burst_writer
#(
  parameter int ADDR_WIDTH = 19
)
(
  input  logic                                       aclk,
  input  logic                                       aresetn,
  input  logic [ram_writer_pkg::AXI_ADDR_WIDTH-1:0] cfg_base,
  fifo_rd_if.writer                                  rd,
  output logic [ram_writer_pkg::AXI_ID_WIDTH-1:0]   awid,
  output logic [ram_writer_pkg::AXI_ADDR_WIDTH-1:0] awaddr,
  output logic                                       awvalid,
  input  logic                                       awready,
  output logic [ram_writer_pkg::AXI_ID_WIDTH-1:0]   wid,
  output ram_writer_pkg::mem_word_t                  wdata,
  output logic                                       wlast,
  output logic                                       wvalid,
  input  logic                                       wready
);
  import ram_writer_pkg::*;

  localparam int BEAT_BITS = $clog2(BURST_LEN);

  logic [ADDR_WIDTH-1:0]     word_idx;  // Low bits count beats in the burst
  logic [AXI_ID_WIDTH-1:0]   id_q;  // ID of the burst in progress
  logic [AXI_ID_WIDTH-1:0]   awid_q;
  logic [AXI_ADDR_WIDTH-1:0] awaddr_q;
  logic [AXI_ADDR_WIDTH-1:0] byte_offset;
  logic                      awvalid_q;
  logic                      wvalid_q;
  logic                      idle;
  logic                      start;
  logic                      beat_done;
  logic                      last_beat;

  assign idle = ~awvalid_q & ~wvalid_q;
  assign start = idle & rd.burst_ready;  // A full burst is buffered
  assign beat_done = wvalid_q & wready;
  assign last_beat = &word_idx[BEAT_BITS-1:0];
  assign byte_offset = AXI_ADDR_WIDTH'(word_idx) << BYTE_SHIFT;

  // Address channel
  assign awid = awid_q;
  assign awaddr = awaddr_q;
  assign awvalid = awvalid_q;

  // Data channel straight from the FIFO head
  assign wid = id_q;
  assign wdata = rd.rd_data;
  assign wlast = last_beat;
  assign wvalid = wvalid_q;
  assign rd.pop = beat_done;

  // The two channels close on their own handshakes, in either order
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      awvalid_q <= 1'b0;
      wvalid_q <= 1'b0;
      word_idx <= '0;
      id_q <= '0;
    end
    else
    begin
      if (start)
      begin
        awvalid_q <= 1'b1;
        wvalid_q <= 1'b1;
      end
      else
      begin
        if (awvalid_q && awready)
        begin
          awvalid_q <= 1'b0;
        end
        if (beat_done && last_beat)
        begin
          wvalid_q <= 1'b0;  // Recheck the FIFO from idle
        end
      end
      if (beat_done)
      begin
        word_idx <= word_idx + 1'b1;  // Wraps at the address span
      end
      if (beat_done && last_beat)
      begin
        id_q <= id_q + 1'b1;
      end
    end
  end

  // Address and ID held until the address handshake
  always_ff @(posedge aclk)
  begin
    if (start)
    begin
      awaddr_q <= cfg_base + byte_offset;
      awid_q <= id_q;
    end
  end

endmodule

/* fifo_rd_if.sv */
`timescale 1ns/10ps

interface fifo_rd_if;
  import ram_writer_pkg::*;

  mem_word_t rd_data;  // Head word, valid while not empty
  logic      empty;
  logic      burst_ready;  // At least one burst buffered
  logic      pop;

  modport buffer
  (
    output rd_data,
    output empty,
    output burst_ready,
    input  pop
  );

  modport writer
  (
    input  rd_data,
    input  empty,
    input  burst_ready,
    output pop
  );

endinterface

/* list.f */
ram_writer_pkg.sv
fifo_rd_if.sv
word_packer.sv
word_fifo.sv
burst_writer.sv
stream_ram_writer.sv
tb_stream_ram_writer.sv

/* ram_writer_pkg.sv */
package ram_writer_pkg;

  // Memory bus
  localparam int AXI_ADDR_WIDTH = 32;
  localparam int AXI_DATA_WIDTH = 64;
  localparam int AXI_ID_WIDTH = 6;

  // Sample stream word, two per memory word
  localparam int STREAM_WIDTH = 32;

  // Fixed INCR burst of full-width beats
  localparam int BURST_LEN = 16;

  // Word index to byte address
  localparam int BYTE_SHIFT = $clog2(AXI_DATA_WIDTH / 8);

  // Packed memory word, low half holds the earlier stream word
  typedef logic [AXI_DATA_WIDTH-1:0] mem_word_t;

endpackage

/* stream_ram_writer.sv */
`timescale 1ns/10ps

module stream_ram_writer
#(
  parameter int FIFO_DEPTH = 64,
  parameter int ADDR_WIDTH = 19
)
(
  input  logic                                       aclk,
  input  logic                                       aresetn,
  input  logic [ram_writer_pkg::AXI_ADDR_WIDTH-1:0] cfg_base,
  input  logic [ram_writer_pkg::STREAM_WIDTH-1:0]   s_axis_tdata,
  input  logic                                       s_axis_tvalid,
  output logic                                       s_axis_tready,
  output logic [ram_writer_pkg::AXI_ID_WIDTH-1:0]   m_axi_awid,
  output logic [ram_writer_pkg::AXI_ADDR_WIDTH-1:0] m_axi_awaddr,
  output logic                                       m_axi_awvalid,
  input  logic                                       m_axi_awready,
  output logic [ram_writer_pkg::AXI_ID_WIDTH-1:0]   m_axi_wid,
  output logic [ram_writer_pkg::AXI_DATA_WIDTH-1:0] m_axi_wdata,
  output logic                                       m_axi_wlast,
  output logic                                       m_axi_wvalid,
  input  logic                                       m_axi_wready
);
  import ram_writer_pkg::*;

  logic      push;
  mem_word_t push_data;
  logic      full;

  fifo_rd_if fifo_rd ();

  word_packer u_packer
  (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .s_tdata   (s_axis_tdata),
    .s_tvalid  (s_axis_tvalid),
    .s_tready  (s_axis_tready),
    .push      (push),
    .push_data (push_data),
    .full      (full)
  );

  word_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo
  (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .push      (push),
    .push_data (push_data),
    .full      (full),
    .rd        (fifo_rd.buffer)
  );

  burst_writer #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_writer
  (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .cfg_base (cfg_base),
    .rd       (fifo_rd.writer),
    .awid     (m_axi_awid),
    .awaddr   (m_axi_awaddr),
    .awvalid  (m_axi_awvalid),
    .awready  (m_axi_awready),
    .wid      (m_axi_wid),
    .wdata    (m_axi_wdata),
    .wlast    (m_axi_wlast),
    .wvalid   (m_axi_wvalid),
    .wready   (m_axi_wready)
  );

endmodule

/* stream_trace.txt */
# name  base(hex)  backpressure(0/1)  words(dec)  first_word(hex)  step(hex)  bursts(dec)  fills(0/1)
# Stream word i is first_word + i * step; bursts is the expected burst count, fills expects a full FIFO
reset_pack   00010000  0  32   a0000000  00000001  1   0
addr_ids     20000000  0  160  11110000  00000003  5   0
wlast_marks  00400000  0  64   deadbe00  00000101  2   0
backpressure 40000000  1  320  c0000000  00000007  10  1
bp_short     00002000  1  64   0badf00d  10000001  2   0
trailing     00800000  0  70   55550000  00000002  2   0
trailing_bp  01000000  1  100  66660000  00000005  3   0
tail_only    00900000  0  30   77770000  00000001  0   0

/* tb_stream_ram_writer.sv */
`timescale 1ns/10ps

module tb_stream_ram_writer;
  import ram_writer_pkg::*;

  localparam int          CLK_PERIOD = 20;
  localparam int          FIFO_DEPTH = 64;
  localparam int          QUIET_CYCLES = 100;  // Idle window after the last full burst
  localparam logic [31:0] LFSR_SEED = 32'ha652;
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;
  localparam string       TRACE_FILE = "stream_trace.txt";

  logic                      aclk;
  logic                      aresetn;
  logic [AXI_ADDR_WIDTH-1:0] cfg_base;
  logic [STREAM_WIDTH-1:0]   s_axis_tdata;
  logic                      s_axis_tvalid;
  logic                      s_axis_tready;
  logic [AXI_ID_WIDTH-1:0]   m_axi_awid;
  logic [AXI_ADDR_WIDTH-1:0] m_axi_awaddr;
  logic                      m_axi_awvalid;
  logic                      m_axi_awready;
  logic [AXI_ID_WIDTH-1:0]   m_axi_wid;
  logic [AXI_DATA_WIDTH-1:0] m_axi_wdata;
  logic                      m_axi_wlast;
  logic                      m_axi_wvalid;
  logic                      m_axi_wready;

  // Trace contents with one entry per test
  string       t_name [$];
  logic [31:0] t_base [$];
  logic [31:0] t_first [$];
  logic [31:0] t_step [$];
  int          t_bp [$];
  int          t_words [$];
  int          t_bursts [$];
  int          t_fills [$];

  string       test_name;
  logic [31:0] cur_base;
  logic [31:0] cur_first;
  logic [31:0] cur_step;
  int          cur_bp;
  int          cur_words;
  int          sent;  // Accepted stream words
  int          beats;
  int          aw_count;
  int          extra_aw;
  logic        saw_full;
  logic        tvalid_held;
  logic        quiet;
  logic [31:0] lfsr;
  int          value_errors = 0;
  int          other_errors = 0;
  int          limit_cycles = 0;
  int          total_words = 0;

  stream_ram_writer #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .ADDR_WIDTH (19)
  ) uut
  (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .cfg_base      (cfg_base),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .m_axi_awid    (m_axi_awid),
    .m_axi_awaddr  (m_axi_awaddr),
    .m_axi_awvalid (m_axi_awvalid),
    .m_axi_awready (m_axi_awready),
    .m_axi_wid     (m_axi_wid),
    .m_axi_wdata   (m_axi_wdata),
    .m_axi_wlast   (m_axi_wlast),
    .m_axi_wvalid  (m_axi_wvalid),
    .m_axi_wready  (m_axi_wready)
  );

  initial
  begin
    aclk = 1'b0;
    forever #(CLK_PERIOD / 2) aclk = ~aclk;
  end

  function automatic logic [31:0] next_lfsr(input logic [31:0] state);
    return (state >> 1) ^ (state[0] ? LFSR_TAPS : 32'h0);  // Galois form
  endfunction

  task automatic take_bit(output logic b);
    b = lfsr[0];
    lfsr = next_lfsr(lfsr);
  endtask

  function automatic logic [31:0] stream_word(input int idx);
    return cur_first + cur_step * 32'(idx);
  endfunction

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (expected === actual)
    else
    begin
      value_errors++;
      $display("Fail %0s %0s: expected %0h, actual %0h", test_name, what, expected, actual);
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    assert (cond)
    else
    begin
      other_errors++;
      $display("Test %0s: %0s", test_name, msg);
    end
  endtask

  task automatic load_trace();
    int           fd;
    int           n;
    string        line;
    logic [127:0] name_r;
    logic [31:0]  base_r;
    logic [31:0]  first_r;
    logic [31:0]  step_r;
    int           bp_r;
    int           words_r;
    int           bursts_r;
    int           fills_r;
    fd = $fopen(TRACE_FILE, "r");
    if (fd != 0)
    begin
      while (!$feof(fd))
      begin
        n = $fgets(line, fd);
        if (n > 1 && line.getc(0) != "#")  // Skip column notes and blank lines
        begin
          n = $sscanf(line, "%s %h %d %d %h %h %d %d", name_r, base_r, bp_r, words_r,
                      first_r, step_r, bursts_r, fills_r);
          if (n == 8)
          begin
            t_name.push_back(string'(name_r));
            t_base.push_back(base_r);
            t_bp.push_back(bp_r);
            t_words.push_back(words_r);
            t_first.push_back(first_r);
            t_step.push_back(step_r);
            t_bursts.push_back(bursts_r);
            t_fills.push_back(fills_r);
            total_words += words_r;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Drive on the falling edge and record the handshakes of the next rising edge
  task automatic step_cycle();
    logic b0;
    logic b1;
    logic b2;
    logic exp_ready;
    @(negedge aclk);
    if (cur_bp != 0)
    begin
      take_bit(b0);
      take_bit(b1);
      take_bit(b2);
      m_axi_wready = b0 & b1 & b2;  // Mostly stalled so the FIFO fills
      take_bit(b0);
      m_axi_awready = b0;
    end
    else
    begin
      m_axi_wready = 1'b1;
      m_axi_awready = 1'b1;
    end
    if (sent >= cur_words)
    begin
      s_axis_tvalid = 1'b0;
    end
    else if (tvalid_held || cur_bp == 0)
    begin
      s_axis_tvalid = 1'b1;  // An offered word stays until taken
    end
    else
    begin
      take_bit(b0);
      take_bit(b1);
      s_axis_tvalid = b0 | b1;
    end
    s_axis_tdata = stream_word(sent);

    // FIFO holds the packed pairs not yet written
    exp_ready = ((sent / 2) - beats) < FIFO_DEPTH;
    check_value("s_axis_tready", 64'(exp_ready), 64'(s_axis_tready));
    if (!s_axis_tready)
    begin
      saw_full = 1'b1;
    end
    tvalid_held = s_axis_tvalid & ~s_axis_tready;
    if (s_axis_tvalid && s_axis_tready)
    begin
      sent++;
    end
    if (m_axi_awvalid && m_axi_awready)
    begin
      check_value("awaddr", 64'(cur_base + 32'(aw_count) * 32'd128), 64'(m_axi_awaddr));
      check_value("awid", 64'(aw_count % 64), 64'(m_axi_awid));
      aw_count++;
    end
    if (m_axi_wvalid && m_axi_wready)
    begin
      check_value("wdata", {stream_word(2 * beats + 1), stream_word(2 * beats)}, m_axi_wdata);
      check_value("wlast", 64'((beats % 16) == 15), 64'(m_axi_wlast));
      check_value("wid", 64'((beats / 16) % 64), 64'(m_axi_wid));
      beats++;
    end
    if (quiet && m_axi_awvalid)
    begin
      extra_aw++;
    end
  endtask

  task automatic run_test(input int idx);
    test_name = t_name[idx];
    cur_base = t_base[idx];
    cur_first = t_first[idx];
    cur_step = t_step[idx];
    cur_bp = t_bp[idx];
    cur_words = t_words[idx];
    sent = 0;
    beats = 0;
    aw_count = 0;
    extra_aw = 0;
    saw_full = 1'b0;
    tvalid_held = 1'b0;
    quiet = 1'b0;
    @(negedge aclk);
    aresetn = 1'b0;  // Burst and ID counters restart per test
    cfg_base = cur_base;
    s_axis_tvalid = 1'b0;
    m_axi_awready = 1'b0;
    m_axi_wready = 1'b0;
    repeat (5) @(negedge aclk);
    aresetn = 1'b1;
    check_value("awvalid after reset", 64'd0, 64'(m_axi_awvalid));
    check_value("wvalid after reset", 64'd0, 64'(m_axi_wvalid));
    check_value("s_axis_tready after reset", 64'd1, 64'(s_axis_tready));
    while (sent < cur_words || beats < 16 * t_bursts[idx] || aw_count < t_bursts[idx])
    begin
      step_cycle();
    end
    quiet = 1'b1;
    repeat (QUIET_CYCLES) step_cycle();
    check_value("beats from accepted pairs", 64'(16 * ((sent / 2) / 16)), 64'(beats));
    check_value("beat count", 64'(16 * t_bursts[idx]), 64'(beats));
    check_value("burst count", 64'(t_bursts[idx]), 64'(aw_count));
    check_true(extra_aw == 0, "a burst started with fewer than 16 words buffered");
    if (t_fills[idx] != 0)
    begin
      check_true(saw_full, "s_axis_tready never dropped, the FIFO did not fill");
    end
    $display("Test %0s: %0d words, %0d bursts, %0d beats", test_name, sent, aw_count, beats);
  endtask

  task automatic finish_run();
    $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0)
    begin
      $display("RESULT: PASS");
    end
    else
    begin
      $display("RESULT: FAIL");
    end
    $finish;
  endtask

  initial
  begin
    aresetn = 1'b0;
    cfg_base = '0;
    s_axis_tdata = '0;
    s_axis_tvalid = 1'b0;
    m_axi_awready = 1'b0;
    m_axi_wready = 1'b0;
    lfsr = LFSR_SEED;
    test_name = "setup";
    cur_bp = 0;
    load_trace();
    if (t_name.size() > 0)
    begin
      limit_cycles = 40 * total_words + 2000;
      foreach (t_name[i])
      begin
        run_test(i);
      end
    end
    else
    begin
      other_errors++;
      $display("Trace file %0s could not be read or holds no tests", TRACE_FILE);
    end
    finish_run();
  end

  // Watchdog armed once the trace length is known
  initial
  begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge aclk);
    other_errors++;
    $display("Timeout: test %0s still running after %0d cycles", test_name, limit_cycles);
    finish_run();
  end

endmodule

/* word_fifo.sv */
`timescale 1ns/10ps

module word_fifo
#(
  parameter int FIFO_DEPTH = 64
)
(
  input  logic                      aclk,
  input  logic                      aresetn,
  input  logic                      push,
  input  ram_writer_pkg::mem_word_t push_data,
  output logic                      full,
  fifo_rd_if.buffer                 rd
);
  import ram_writer_pkg::*;

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  mem_word_t  mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;  // Occupancy in memory words
  logic             empty;
  logic             do_push;
  logic             do_pop;

  assign full = (count == CNT_W'(FIFO_DEPTH));
  assign empty = (count == '0);
  assign do_push = push & ~full;
  assign do_pop = rd.pop & ~empty;

  // Fall-through read port
  assign rd.rd_data = mem[rd_ptr];
  assign rd.empty = empty;
  assign rd.burst_ready = (count >= CNT_W'(BURST_LEN));

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end
    else
    begin
      if (do_push)
      begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // Wrap for any depth
      end
      if (do_pop)
      begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;  // Both or neither leave it unchanged
      endcase
    end
  end

  always_ff @(posedge aclk)
  begin
    if (do_push)
    begin
      mem[wr_ptr] <= push_data;
    end
  end

endmodule

/* word_packer.sv */
`timescale 1ns/10ps

module word_packer
(
  input  logic                                     aclk,
  input  logic                                     aresetn,
  input  logic [ram_writer_pkg::STREAM_WIDTH-1:0] s_tdata,
  input  logic                                     s_tvalid,
  output logic                                     s_tready,
  output logic                                     push,
  output ram_writer_pkg::mem_word_t                push_data,
  input  logic                                     full
);
  import ram_writer_pkg::*;

  logic [STREAM_WIDTH-1:0] first_q;  // Low half of the pending pair
  logic                    second_q;  // Next accepted word closes a pair
  logic                    accept;

  assign s_tready = ~full;
  assign accept = s_tvalid & s_tready;

  // Push on the cycle the second word is taken
  assign push = accept & second_q;
  assign push_data = {s_tdata, first_q};

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      second_q <= 1'b0;
    end
    else if (accept)
    begin
      second_q <= ~second_q;  // Toggle only on a real handshake
    end
  end

  always_ff @(posedge aclk)
  begin
    if (accept && !second_q)
    begin
      first_q <= s_tdata;
    end
  end

endmodule
